// ==== design/midiPkg.sv ====
//--------------------
// midi front end shared definitions
// byte and field types, channel message
// status nibbles and apb register map
//--------------------
package midiPkg;

	// raw byte and message fields
	typedef logic [7:0] midiByteT;
	typedef logic [6:0] noteNumT;
	typedef logic [6:0] velocityT;
	typedef logic [3:0] channelT;
	typedef logic [15:0] countT;

	// upper nibble of channel status bytes
	localparam logic [3:0] STATUS_NOTE_OFF      = 4'h8;
	localparam logic [3:0] STATUS_NOTE_ON       = 4'h9;
	localparam logic [3:0] STATUS_PROG_CHANGE   = 4'hC;
	localparam logic [3:0] STATUS_CHAN_PRESSURE = 4'hD;

	// apb byte offsets
	localparam logic [7:0] ADDR_CTRL  = 8'h00;
	localparam logic [7:0] ADDR_COUNT = 8'h04;
	localparam logic [7:0] ADDR_MAP0  = 8'h08;
	localparam logic [7:0] ADDR_MAP1  = 8'h0C;
	localparam logic [7:0] ADDR_MAP2  = 8'h10;
	localparam logic [7:0] ADDR_MAP3  = 8'h14;
	localparam logic [7:0] ADDR_LAST  = 8'h18;

endpackage

// ==== design/noteEventIf.sv ====
//--------------------
// note event link
// one decoded note on or off per strobe
//--------------------
`timescale 1ns/1ns

interface noteEventIf;

	// fields only meaningful while valid is high
	logic valid;
	logic isOn;
	midiPkg::channelT channel;
	midiPkg::noteNumT number;
	midiPkg::velocityT velocity;

	modport source (output valid, output isOn, output channel, output number, output velocity);
	modport sink (input valid, input isOn, input channel, input number, input velocity);

endinterface

// ==== design/noteStatusIf.sv ====
//--------------------
// note table status link
// table state out to the registers,
// count clear strobe coming back
//--------------------
`timescale 1ns/1ns

interface noteStatusIf;

	logic [127:0] activeMap;
	midiPkg::noteNumT lastNumber;
	midiPkg::velocityT lastVelocity;
	logic lastOn;
	midiPkg::countT eventCount;
	// one cycle strobe from the register side
	logic clearCount;

	modport provider (output activeMap, output lastNumber, output lastVelocity,
		output lastOn, output eventCount, input clearCount);
	modport reader (input activeMap, input lastNumber, input lastVelocity,
		input lastOn, input eventCount, output clearCount);

endinterface

// ==== design/baudTimer.sv ====
//--------------------
// baud timer
// bit centre sample ticks for the uart,
// half period after restart then full periods
//--------------------
`timescale 1ns/1ns

module baudTimer #(
	parameter int CLKS_PER_BIT = 1600
) (
	input  logic iCLK,
	input  logic iRST,
	input  logic restart,
	input  logic run,
	output logic tick
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	// reload values, counter expires at zero
	localparam logic [CW-1:0] HALF_LOAD = CW'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CW-1:0] FULL_LOAD = CW'(CLKS_PER_BIT - 1);

	logic [CW-1:0] rCount;

	// expiry only counts while the frame is running
	assign tick = run & (rCount == '0);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rCount <= '0;
		else if (restart)
			// aim at the middle of the start bit
			rCount <= HALF_LOAD;
		else if (tick)
			rCount <= FULL_LOAD;
		else if (run)
			rCount <= rCount - 1'b1;
	end

endmodule

// ==== design/midiUartRx.sv ====
//--------------------
// midi serial receiver
// 8N1 frames, lsb first, one byte strobe
// per frame with a good stop bit
//--------------------
`timescale 1ns/1ns

module midiUartRx #(
	parameter int CLKS_PER_BIT = 1600
) (
	input  logic iCLK,
	input  logic iRST,
	input  logic rxd,
	output midiPkg::midiByteT rxByte,
	output logic byteValid
);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} stateT;

	stateT rState;
	logic [2:0] rSync;
	logic [2:0] rBitCnt;
	midiPkg::midiByteT rShift;
	logic qFall;
	logic qTick;
	logic qRxd;

	// two sync flops plus one for edge detect
	assign qRxd = rSync[1];
	assign qFall = (rState == S_IDLE) & rSync[2] & ~rSync[1];

	baudTimer #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_baudTimer (
		.iCLK(iCLK),
		.iRST(iRST),
		.restart(qFall),
		.run(rState != S_IDLE),
		.tick(qTick)
	);

	// strobe right at the stop bit sample
	assign byteValid = (rState == S_STOP) & qTick & qRxd;
	assign rxByte = rShift;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			// line idles high
			rSync <= 3'b111;
			rState <= S_IDLE;
			rBitCnt <= 3'd0;
		end
		else
		begin
			rSync <= {rSync[1:0], rxd};
			case (rState)
				S_IDLE:
					if (qFall)
						rState <= S_START;
				S_START:
					// glitch guard, start bit must still be low
					if (qTick)
					begin
						rState <= qRxd ? S_IDLE : S_DATA;
						rBitCnt <= 3'd0;
					end
				S_DATA:
					if (qTick)
					begin
						rBitCnt <= rBitCnt + 1'b1;
						if (rBitCnt == 3'd7)
							rState <= S_STOP;
					end
				default:
					// bad stop bit just drops the frame
					if (qTick)
						rState <= S_IDLE;
			endcase
		end
	end

	// data shifts in from the top, lsb first on the wire
	always_ff @(posedge iCLK)
	begin
		if ((rState == S_DATA) && qTick)
			rShift <= {qRxd, rShift[7:1]};
	end

endmodule

// ==== design/midiDecoder.sv ====
//--------------------
// midi message decoder
// running status, channel filter,
// note on / note off event strobes
//--------------------
`timescale 1ns/1ns

module midiDecoder (
	input  logic iCLK,
	input  logic iRST,
	input  midiPkg::midiByteT rxByte,
	input  logic byteValid,
	input  logic enable,
	input  logic omni,
	input  midiPkg::channelT listenChannel,
	noteEventIf.source evt
);

	logic rHaveStatus;
	logic rSecond;
	logic [3:0] rStatus;
	midiPkg::channelT rChannel;
	midiPkg::noteNumT rNumber;
	logic qIsStatus, qIsCommon, qIsData;
	logic qOneByte, qIsNote, qChanOk, qFire;

	//--------------------
	// byte classes
	//--------------------
	// 0x80..0xEF channel status
	assign qIsStatus = byteValid & rxByte[7] & (rxByte[7:4] != 4'hF);
	// 0xF0..0xF7 system common, realtime falls through untouched
	assign qIsCommon = byteValid & (rxByte[7:3] == 5'b11110);
	assign qIsData = byteValid & ~rxByte[7] & rHaveStatus;

	// program change and channel pressure carry one data byte
	assign qOneByte = (rStatus == midiPkg::STATUS_PROG_CHANGE) |
		(rStatus == midiPkg::STATUS_CHAN_PRESSURE);
	assign qIsNote = (rStatus == midiPkg::STATUS_NOTE_ON) |
		(rStatus == midiPkg::STATUS_NOTE_OFF);
	assign qChanOk = omni | (rChannel == listenChannel);
	// last data byte of a note message that passes the filter
	assign qFire = qIsData & (qOneByte | rSecond) & qIsNote & enable & qChanOk;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			rHaveStatus <= 1'b0;
			rSecond <= 1'b0;
			evt.valid <= 1'b0;
		end
		else
		begin
			evt.valid <= qFire;
			if (qIsStatus)
			begin
				rHaveStatus <= 1'b1;
				rSecond <= 1'b0;
			end
			else if (qIsCommon)
			begin
				rHaveStatus <= 1'b0;
				rSecond <= 1'b0;
			end
			else if (qIsData)
				// back to first data byte after each message
				rSecond <= qOneByte ? 1'b0 : ~rSecond;
		end
	end

	// message fields
	always_ff @(posedge iCLK)
	begin
		if (qIsStatus)
		begin
			rStatus <= rxByte[7:4];
			rChannel <= rxByte[3:0];
		end
		if (qIsData & ~rSecond)
			rNumber <= rxByte[6:0];
		if (qFire)
		begin
			// velocity 0 note on counts as note off
			evt.isOn <= (rStatus == midiPkg::STATUS_NOTE_ON) & (rxByte[6:0] != 7'd0);
			evt.channel <= rChannel;
			evt.number <= rNumber;
			evt.velocity <= rxByte[6:0];
		end
	end

endmodule

// ==== design/noteTable.sv ====
//--------------------
// active note table
// 128 bit note map, last event record
// and a wrapping event counter
//--------------------
`timescale 1ns/1ns

module noteTable (
	input  logic iCLK,
	input  logic iRST,
	noteEventIf.sink evt,
	noteStatusIf.provider status
);

	logic [127:0] rMap;
	midiPkg::noteNumT rLastNumber;
	midiPkg::velocityT rLastVelocity;
	logic rLastOn;
	midiPkg::countT rCount;

	assign status.activeMap = rMap;
	assign status.lastNumber = rLastNumber;
	assign status.lastVelocity = rLastVelocity;
	assign status.lastOn = rLastOn;
	assign status.eventCount = rCount;

	//--------------------
	// note map and last event
	//--------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			rMap <= '0;
			rLastNumber <= '0;
			rLastVelocity <= '0;
			rLastOn <= 1'b0;
		end
		else if (evt.valid)
		begin
			// map ignores channel, one bit per note number
			rMap[evt.number] <= evt.isOn;
			rLastNumber <= evt.number;
			rLastVelocity <= evt.velocity;
			rLastOn <= evt.isOn;
		end
	end

	// event counter, clear wins over a same cycle event
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rCount <= '0;
		else if (status.clearCount)
			rCount <= '0;
		else if (evt.valid)
			rCount <= rCount + 1'b1;
	end

endmodule

// ==== design/midiApbRegs.sv ====
//--------------------
// apb register block
// control register, event count and
// read only note map / last event
//--------------------
`timescale 1ns/1ns

module midiApbRegs (
	input  logic iCLK,
	input  logic iRST,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic enable,
	output logic omni,
	output midiPkg::channelT listenChannel,
	noteStatusIf.reader status
);

	logic qWrite;
	logic rClear;

	// access phase, no wait states
	assign qWrite = psel & penable & pwrite;
	assign status.clearCount = rClear;

	//--------------------
	// writes
	//--------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			// decoder on, all channels
			enable <= 1'b1;
			omni <= 1'b1;
			listenChannel <= '0;
			rClear <= 1'b0;
		end
		else
		begin
			// any value written to count clears it
			rClear <= qWrite & (paddr == midiPkg::ADDR_COUNT);
			if (qWrite && (paddr == midiPkg::ADDR_CTRL))
			begin
				enable <= pwdata[0];
				omni <= pwdata[1];
				listenChannel <= pwdata[7:4];
			end
		end
	end

	// read mux, zero when not selected
	always_comb
	begin
		prdata = '0;
		if (psel)
		begin
			case (paddr)
				midiPkg::ADDR_CTRL:  prdata = {24'd0, listenChannel, 2'b00, omni, enable};
				midiPkg::ADDR_COUNT: prdata = {16'd0, status.eventCount};
				midiPkg::ADDR_MAP0:  prdata = status.activeMap[31:0];
				midiPkg::ADDR_MAP1:  prdata = status.activeMap[63:32];
				midiPkg::ADDR_MAP2:  prdata = status.activeMap[95:64];
				midiPkg::ADDR_MAP3:  prdata = status.activeMap[127:96];
				// number 6:0, velocity 14:8, on flag 16
				midiPkg::ADDR_LAST:  prdata = {15'd0, status.lastOn, 1'b0,
					status.lastVelocity, 1'b0, status.lastNumber};
				default:             prdata = '0;
			endcase
		end
	end

endmodule

// ==== design/midiFront.sv ====
//--------------------
// midi receive front end
// uart, decoder, note table and apb regs
//--------------------
`timescale 1ns/1ns

module midiFront #(
	// 31250 baud from 50 MHz
	parameter int CLKS_PER_BIT = 1600
) (
	input  logic iCLK,
	input  logic iRST,
	input  logic rxd,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata
);

	midiPkg::midiByteT rxByte;
	logic byteValid;
	logic enable;
	logic omni;
	midiPkg::channelT listenChannel;

	noteEventIf evtLink ();
	noteStatusIf statusLink ();

	midiUartRx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_midiUartRx (
		.iCLK(iCLK), .iRST(iRST), .rxd(rxd), .rxByte(rxByte), .byteValid(byteValid)
	);

	midiDecoder u_midiDecoder (
		.iCLK(iCLK), .iRST(iRST), .rxByte(rxByte), .byteValid(byteValid),
		.enable(enable), .omni(omni), .listenChannel(listenChannel), .evt(evtLink.source)
	);

	noteTable u_noteTable (
		.iCLK(iCLK), .iRST(iRST), .evt(evtLink.sink), .status(statusLink.provider)
	);

	midiApbRegs u_midiApbRegs (
		.iCLK(iCLK), .iRST(iRST), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .enable(enable), .omni(omni),
		.listenChannel(listenChannel), .status(statusLink.reader)
	);

endmodule

// ==== test/midiFrontChecker.sv ====
//--------------------
// decoder event checker
// strobe timing and channel filter rules
// on the note event, bound into every decoder
//--------------------
`timescale 1ns/1ns

module midiFrontChecker (
	input logic iCLK,
	input logic iRST,
	input logic byteValid,
	input logic omni,
	input midiPkg::channelT listenChannel,
	input logic evtValid,
	input midiPkg::channelT evtChannel
);

	// running total of assertion failures
	int failCount = 0;

	// event is a single cycle strobe
	singleStrobe: assert property (@(posedge iCLK) disable iff (iRST)
		evtValid |=> !evtValid)
		else
		begin
			$error("decoder event valid high on two consecutive cycles");
			failCount++;
		end

	// only ever the cycle after a received byte
	afterByte: assert property (@(posedge iCLK) disable iff (iRST)
		evtValid |-> $past(byteValid))
		else
		begin
			$error("decoder event valid without a byte strobe one cycle earlier");
			failCount++;
		end

	// flop is cleared by a reset cycle
	quietInReset: assert property (@(posedge iCLK)
		iRST |=> !evtValid)
		else
		begin
			$error("decoder event valid high after a reset cycle");
			failCount++;
		end

	// filtered events carry the listened channel
	channelFilter: assert property (@(posedge iCLK) disable iff (iRST)
		evtValid && !$past(omni) |-> evtChannel == $past(listenChannel))
		else
		begin
			$error("decoder event channel does not match the listened channel");
			failCount++;
		end

endmodule

bind midiDecoder midiFrontChecker u_midiFrontChecker (
	.iCLK(iCLK),
	.iRST(iRST),
	.byteValid(byteValid),
	.omni(omni),
	.listenChannel(listenChannel),
	.evtValid(evt.valid),
	.evtChannel(evt.channel)
);

// ==== test/midiFrontTb.sv ====
//--------------------
// midi front end testbench
// serial byte driver, apb access tasks,
// reference model of decoder and note table
//--------------------
`timescale 1ns/1ns

module midiFrontTb;

	localparam int CLKS_PER_BIT = 16;
	// upper bound on bytes sent over all tests
	localparam int MAX_BYTES = 300;
	localparam int WATCHDOG_NS = 2 * MAX_BYTES * 10 * CLKS_PER_BIT * 20;

	logic iCLK;
	logic iRST;
	logic rxd;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;

	// model state
	logic mHaveStatus;
	logic mSecond;
	logic [3:0] mStatus;
	logic [3:0] mChannel;
	logic [6:0] mNumber;
	logic [127:0] mMap;
	logic [6:0] mLastNum;
	logic [6:0] mLastVel;
	logic mLastOn;
	logic [15:0] mCount;
	logic mEnable;
	logic mOmni;
	logic [3:0] mListen;
	// running status as seen by the sender
	logic [7:0] txStatus;

	int errorCount;
	int testCount;
	int testErrStart;

	midiFront #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_midiFront (
		.iCLK(iCLK), .iRST(iRST), .rxd(rxd), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #10 iCLK = ~iCLK;
	end

	//--------------------
	// reference model
	//--------------------
	task automatic modelByte(input logic [7:0] b);
		logic done;
		logic isOn;
		done = 1'b0;
		// realtime bytes pass untouched
		if (b < 8'hF8)
		begin
			if (b >= 8'hF0)
			begin
				// system common drops running status
				mHaveStatus = 1'b0;
				mSecond = 1'b0;
			end
			else if (b[7])
			begin
				mHaveStatus = 1'b1;
				mSecond = 1'b0;
				mStatus = b[7:4];
				mChannel = b[3:0];
			end
			else if (mHaveStatus)
			begin
				if (mStatus == midiPkg::STATUS_PROG_CHANGE ||
					mStatus == midiPkg::STATUS_CHAN_PRESSURE)
					done = 1'b1;
				else if (!mSecond)
				begin
					mNumber = b[6:0];
					mSecond = 1'b1;
				end
				else
				begin
					done = 1'b1;
					mSecond = 1'b0;
				end
				if (done && mEnable && (mOmni || mChannel == mListen) &&
					(mStatus == midiPkg::STATUS_NOTE_ON ||
					mStatus == midiPkg::STATUS_NOTE_OFF))
				begin
					// zero velocity note on means note off
					isOn = (mStatus == midiPkg::STATUS_NOTE_ON) && (b[6:0] != 7'd0);
					mMap[mNumber] = isOn;
					mLastNum = mNumber;
					mLastVel = b[6:0];
					mLastOn = isOn;
					mCount = mCount + 16'd1;
				end
			end
		end
	endtask

	//--------------------
	// stimulus tasks
	//--------------------
	// start, 8 data bits lsb first, stop, one idle bit
	task automatic sendByte(input logic [7:0] b, input logic stopBit);
		logic [10:0] frame;
		frame = {1'b1, stopBit, b, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			@(posedge iCLK);
			#2;
			rxd = frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge iCLK);
		end
		// a dropped frame never reaches the model
		if (stopBit)
		begin
			modelByte(b);
			if (b >= 8'hF0 && b < 8'hF8)
				txStatus = 8'h00;
			else if (b[7] && b < 8'hF0)
				txStatus = b;
		end
	endtask

	task automatic sendNote(input logic [3:0] stat, input logic [3:0] ch,
		input logic [6:0] num, input logic [6:0] vel, input logic allowRun);
		logic [7:0] sb;
		sb = {stat, ch};
		// skip status byte when running status already matches
		if (!(allowRun && sb == txStatus))
			sendByte(sb, 1'b1);
		sendByte({1'b0, num}, 1'b1);
		sendByte({1'b0, vel}, 1'b1);
	endtask

	task automatic randomNotes(input int n, input logic favorCh5);
		logic [3:0] stat;
		logic [3:0] ch;
		logic [6:0] num;
		logic [6:0] vel;
		ch = 4'($urandom % 16);
		for (int i = 0; i < n; i++)
		begin
			stat = ($urandom % 2) ? midiPkg::STATUS_NOTE_ON : midiPkg::STATUS_NOTE_OFF;
			if (favorCh5)
				ch = ($urandom % 2) ? 4'd5 : 4'($urandom % 16);
			else if ($urandom % 4 == 0)
				// sticky channel gives running status a chance
				ch = 4'($urandom % 16);
			num = 7'(36 + $urandom % 64);
			vel = 7'($urandom % 128);
			sendNote(stat, ch, num, vel, 1'($urandom % 2));
		end
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
		@(posedge iCLK);
		#2;
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge iCLK);
		#2;
		penable = 1'b1;
		@(posedge iCLK);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
		@(posedge iCLK);
		#2;
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge iCLK);
		#2;
		penable = 1'b1;
		// prdata settled by mid access phase
		@(negedge iCLK);
		data = prdata;
		@(posedge iCLK);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic setCtrl(input logic en, input logic om, input logic [3:0] ch);
		apbWrite(midiPkg::ADDR_CTRL, {24'd0, ch, 2'b00, om, en});
		mEnable = en;
		mOmni = om;
		mListen = ch;
	endtask

	//--------------------
	// checking
	//--------------------
	task automatic compareReg(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t ns %s expected %08h actual %08h", $time, name, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkRegs();
		logic [31:0] v;
		apbRead(midiPkg::ADDR_CTRL, v);
		compareReg("CTRL", {24'd0, mListen, 2'b00, mOmni, mEnable}, v);
		apbRead(midiPkg::ADDR_COUNT, v);
		compareReg("COUNT", {16'd0, mCount}, v);
		apbRead(midiPkg::ADDR_MAP0, v);
		compareReg("MAP0", mMap[31:0], v);
		apbRead(midiPkg::ADDR_MAP1, v);
		compareReg("MAP1", mMap[63:32], v);
		apbRead(midiPkg::ADDR_MAP2, v);
		compareReg("MAP2", mMap[95:64], v);
		apbRead(midiPkg::ADDR_MAP3, v);
		compareReg("MAP3", mMap[127:96], v);
		apbRead(midiPkg::ADDR_LAST, v);
		compareReg("LAST", {15'd0, mLastOn, 1'b0, mLastVel, 1'b0, mLastNum}, v);
	endtask

	// margin after the last frame before polling
	task automatic settle();
		repeat (8) @(posedge iCLK);
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("test %0d %s: %0d errors", testCount, name, errorCount - testErrStart);
		testErrStart = errorCount;
	endtask

	//--------------------
	// test sequence
	//--------------------
	initial
	begin
		void'($urandom(32'h63f8_a245));
		iRST = 1'b1;
		rxd = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		mHaveStatus = 1'b0;
		mSecond = 1'b0;
		mStatus = 4'h0;
		mChannel = 4'h0;
		mNumber = 7'h0;
		mMap = '0;
		mLastNum = 7'h0;
		mLastVel = 7'h0;
		mLastOn = 1'b0;
		mCount = 16'h0;
		mEnable = 1'b1;
		mOmni = 1'b1;
		mListen = 4'h0;
		txStatus = 8'h00;
		errorCount = 0;
		testCount = 0;
		testErrStart = 0;
		repeat (16) @(posedge iCLK);
		#2;
		iRST = 1'b0;

		checkRegs();
		endTest("reset values");

		randomNotes(40, 1'b0);
		settle();
		checkRegs();
		endTest("random notes omni");

		setCtrl(1'b1, 1'b0, 4'd5);
		randomNotes(30, 1'b1);
		settle();
		checkRegs();
		// disabled decoder must hold all state
		setCtrl(1'b0, 1'b0, 4'd5);
		randomNotes(10, 1'b1);
		settle();
		checkRegs();
		setCtrl(1'b1, 1'b1, 4'd0);
		endTest("channel filter and enable");

		// realtime bytes inside a note on
		sendByte(8'h90, 1'b1);
		sendByte(8'hF8, 1'b1);
		sendByte(8'h3C, 1'b1);
		sendByte(8'hFE, 1'b1);
		sendByte(8'h64, 1'b1);
		// program change and one more by running status
		sendByte(8'hC3, 1'b1);
		sendByte(8'h10, 1'b1);
		sendByte(8'h11, 1'b1);
		sendByte(8'hB2, 1'b1);
		sendByte(8'h07, 1'b1);
		sendByte(8'h40, 1'b1);
		sendByte(8'h93, 1'b1);
		sendByte(8'h3D, 1'b1);
		sendByte(8'h50, 1'b1);
		// stray data after system common
		sendByte(8'hF2, 1'b1);
		sendByte(8'h30, 1'b1);
		sendByte(8'h31, 1'b1);
		// velocity byte with bad stop is lost
		sendByte(8'h92, 1'b1);
		sendByte(8'h40, 1'b1);
		sendByte(8'h55, 1'b0);
		sendByte(8'h56, 1'b1);
		sendByte(8'h80, 1'b0);
		sendByte(8'h3C, 1'b1);
		sendByte(8'h00, 1'b1);
		settle();
		checkRegs();
		endTest("other messages and bad frames");

		sendNote(midiPkg::STATUS_NOTE_ON, 4'd1, 7'h33, 7'h40, 1'b0);
		sendNote(midiPkg::STATUS_NOTE_ON, 4'd1, 7'h33, 7'h00, 1'b1);
		settle();
		checkRegs();
		endTest("velocity zero note off");

		apbWrite(midiPkg::ADDR_COUNT, $urandom);
		mCount = 16'h0;
		settle();
		checkRegs();
		sendNote(midiPkg::STATUS_NOTE_ON, 4'd2, 7'h45, 7'h20, 1'b0);
		settle();
		checkRegs();
		endTest("count clear");

		// assertion failures from the bound checker
		if (u_midiFront.u_midiDecoder.u_midiFrontChecker.failCount != 0)
		begin
			$display("decoder checker assertions failed %0d times",
				u_midiFront.u_midiDecoder.u_midiFrontChecker.failCount);
			errorCount += u_midiFront.u_midiDecoder.u_midiFrontChecker.failCount;
		end

		$display("tests run %0d, errors %0d", testCount, errorCount);
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== build.f ====
design/midiPkg.sv
design/noteEventIf.sv
design/noteStatusIf.sv
design/baudTimer.sv
design/midiUartRx.sv
design/midiDecoder.sv
design/noteTable.sv
design/midiApbRegs.sv
design/midiFront.sv
test/midiFrontChecker.sv
test/midiFrontTb.sv
